/* design/fetch_pkg.sv */
// Shared definitions for the instruction fetch stage and its predictor
// Imported by the fetch RTL and by the testbench to build and check words

`default_nettype none

package fetch_pkg;

	// RV32I major opcodes, instruction bits 6:0
	typedef enum logic [6:0] {
		LOAD   = 7'b000_0011,
		OP_IMM = 7'b001_0011,
		AUIPC  = 7'b001_0111,
		STORE  = 7'b010_0011,
		OP     = 7'b011_0011,
		LUI    = 7'b011_0111,
		BRANCH = 7'b110_0011,
		JALR   = 7'b110_0111,
		JAL    = 7'b110_1111,
		SYSTEM = 7'b111_0011
	} opcode_e;

	// Configuration register map
	typedef enum logic [0:0] {
		CFG_TVEC = 1'b0,
		CFG_CTRL = 1'b1
	} cfg_addr_e;

	// First fetch address out of reset
	localparam logic [31:0] PC_RESET = 32'h0000_0000;

	// addi x0, x0, 0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

	// Trap target until software writes CFG_TVEC
	localparam logic [31:0] TVEC_RESET = 32'h0000_0100;

	// Predictor size at the top level, power of two
	localparam int BPU_ENTRIES_DEF = 16;

endpackage

`default_nettype wire

/* design/fetch_config.sv */
// Fetch configuration registers: trap vector and prediction enable
// Written through a single-cycle strobe, read back combinationally by address

`timescale 1ns/100ps
`default_nettype none

module fetch_config import fetch_pkg::*; (
	input wire clk,
	input wire rst_n,
	// Register write strobe and address
	input wire i_cfg_we,
	input wire cfg_addr_e i_cfg_addr,
	input wire [31:0] i_cfg_wdata,
	// Readback of the addressed register
	output logic [31:0] o_cfg_rdata,
	// Values used by the fetch stage and predictor
	output logic [31:0] o_trap_vec,
	output logic o_predict_en
);

	logic [31:0] trap_vec_q;
	logic predict_en_q;

	// Trap vector register
	// Word aligned, so the two low bits never store a one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			trap_vec_q <= TVEC_RESET;
		end else if (i_cfg_we && (i_cfg_addr == CFG_TVEC)) begin
			trap_vec_q <= {i_cfg_wdata[31:2], 2'b00};
		end
	end

	// Control register, only bit 0 is implemented
	// Prediction is on out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			predict_en_q <= 1'b1;
		end else if (i_cfg_we && (i_cfg_addr == CFG_CTRL)) begin
			predict_en_q <= i_cfg_wdata[0];
		end
	end

	// Readback mux
	// Unimplemented control bits return zero
	always_comb begin
		case (i_cfg_addr)
			CFG_TVEC: o_cfg_rdata = trap_vec_q;
			CFG_CTRL: o_cfg_rdata = {31'd0, predict_en_q};
			default:  o_cfg_rdata = 32'd0;
		endcase
	end

	assign o_trap_vec   = trap_vec_q;
	assign o_predict_en = predict_en_q;

endmodule

`default_nettype wire

/* design/branch_predictor.sv */
// Direct-mapped table of 2-bit saturating counters for conditional branches
// Looked up with the fetch PC, trained by branch resolutions from a later stage
// Target comes from the B-type immediate of the word being fetched

`timescale 1ns/100ps
`default_nettype none

module branch_predictor import fetch_pkg::*; #(
	parameter int BPU_ENTRIES = 16
) (
	input wire clk,
	input wire rst_n,
	// Lookup side, current fetch address and raw word
	input wire [31:0] i_fetch_pc,
	input wire [31:0] i_fetch_instr,
	input wire i_predict_en,
	// Training side, one strobe per resolved branch
	input wire i_resolve_vld,
	input wire [31:0] i_resolve_pc,
	input wire i_resolve_taken,
	// Prediction back to fetch
	output logic o_predict_taken,
	output logic [31:0] o_predicted_pc
);

	localparam int IDX_W = $clog2(BPU_ENTRIES);

	// Counter states, upper bit is the taken decision
	typedef enum logic [1:0] {
		CNT_SNT = 2'd0,
		CNT_WNT = 2'd1,
		CNT_WT  = 2'd2,
		CNT_ST  = 2'd3
	} cnt_e;

	cnt_e cnt_q [BPU_ENTRIES];
	cnt_e cnt_nxt;

	logic [IDX_W-1:0] fetch_idx;
	logic [IDX_W-1:0] resolve_idx;
	logic is_branch;
	logic [31:0] b_imm;

	// Word index, bits 1:0 are always zero
	assign fetch_idx   = i_fetch_pc[IDX_W+1:2];
	assign resolve_idx = i_resolve_pc[IDX_W+1:2];

	// Next state of the counter being trained
	// Saturates at both ends
	always_comb begin
		cnt_nxt = cnt_q[resolve_idx];
		case (cnt_q[resolve_idx])
			CNT_SNT: cnt_nxt = i_resolve_taken ? CNT_WNT : CNT_SNT;
			CNT_WNT: cnt_nxt = i_resolve_taken ? CNT_WT  : CNT_SNT;
			CNT_WT:  cnt_nxt = i_resolve_taken ? CNT_ST  : CNT_WNT;
			CNT_ST:  cnt_nxt = i_resolve_taken ? CNT_ST  : CNT_WT;
			default: cnt_nxt = CNT_WNT;
		endcase
	end

	// Counter table
	// All entries start weakly not taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BPU_ENTRIES; i++) begin
				cnt_q[i] <= CNT_WNT;
			end
		end else if (i_resolve_vld) begin
			cnt_q[resolve_idx] <= cnt_nxt;
		end
	end

	// Only conditional branches are predicted
	assign is_branch = (opcode_e'(i_fetch_instr[6:0]) == BRANCH);

	// B-type immediate, sign extended, bit 0 implied zero
	assign b_imm = {
		{20{i_fetch_instr[31]}},
		i_fetch_instr[7],
		i_fetch_instr[30:25],
		i_fetch_instr[11:8],
		1'b0
	};

	// Lookup reads the table as it stands before any training at this edge
	assign o_predict_taken = is_branch && i_predict_en && cnt_q[fetch_idx][1];
	assign o_predicted_pc  = i_fetch_pc + b_imm;

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
// Instruction fetch stage: program counter, redirect priority and the
// fetch-to-decode register. The ROM answers in the cycle the address is shown,
// so decode sees each word and its PC exactly one clock later.

`timescale 1ns/100ps
`default_nettype none

module fetch_stage import fetch_pkg::*; (
	input wire clk,
	input wire rst_n,
	// Instruction memory
	input wire [31:0] i_rom_instr,
	input wire i_instr_vld,
	output logic [31:0] o_iaddr,
	output logic o_fetch_rdy,
	// Trap request, target from the config block
	input wire i_trap,
	input wire [31:0] i_trap_vec,
	// Resolved branch or jump
	input wire i_boj,
	input wire [31:0] i_boj_pc,
	// Pipeline control
	input wire i_stall,
	input wire i_flush,
	input wire [31:0] i_flush_pc,
	// Prediction for the word at o_iaddr
	input wire i_predict_taken,
	input wire [31:0] i_predicted_pc,
	// Toward decode
	output logic [31:0] o_pc,
	output logic [31:0] o_instr,
	output logic o_prediction
);

	logic [31:0] pc_q;
	logic [31:0] pc_seq;
	logic advance;

	logic [31:0] ir_instr_q;
	logic [31:0] ir_pc_q;
	logic ir_prediction_q;

	// A word moves on only when it is valid and decode can take it
	assign advance = i_instr_vld && !i_stall;
	assign pc_seq  = pc_q + 32'd4;

	// Program counter
	// Order: flush, trap, branch or jump, predicted branch, sequential
	// A stalled branch stays at this address and is looked up again on release
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= PC_RESET;
		end else if (i_flush) begin
			pc_q <= i_flush_pc;
		end else if (i_trap) begin
			pc_q <= i_trap_vec;
		end else if (i_boj) begin
			pc_q <= i_boj_pc;
		end else if (advance) begin
			if (i_predict_taken) begin
				pc_q <= i_predicted_pc;
			end else begin
				pc_q <= pc_seq;
			end
		end
	end

	// Fetch-to-decode register
	// Flush drops the word in flight and sends a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir_instr_q      <= NOP_INSTR;
			ir_pc_q         <= 32'd0;
			ir_prediction_q <= 1'b0;
		end else if (i_flush) begin
			ir_instr_q      <= NOP_INSTR;
			ir_pc_q         <= 32'd0;
			ir_prediction_q <= 1'b0;
		end else if (advance) begin
			ir_instr_q      <= i_rom_instr;
			ir_pc_q         <= pc_q;
			ir_prediction_q <= i_predict_taken;
		end
	end

	// Address straight from the PC register
	assign o_iaddr = pc_q;

	// Ready toward memory, low in reset, stall or flush
	assign o_fetch_rdy = rst_n && !i_stall && !i_flush;

	assign o_instr      = ir_instr_q;
	assign o_pc         = ir_pc_q;
	assign o_prediction = ir_prediction_q;

endmodule

`default_nettype wire

/* design/fetch_top.sv */
// Top level of the fetch unit: config registers, fetch stage and predictor
// Instruction memory sits outside and answers in the same cycle as o_iaddr

`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int BPU_ENTRIES = BPU_ENTRIES_DEF
) (
	input wire clk,
	input wire rst_n,
	// Instruction memory
	input wire [31:0] i_rom_instr,
	input wire i_instr_vld,
	output logic [31:0] o_iaddr,
	output logic o_fetch_rdy,
	// Redirects and pipeline control
	input wire i_trap,
	input wire i_boj,
	input wire [31:0] i_boj_pc,
	input wire i_stall,
	input wire i_flush,
	input wire [31:0] i_flush_pc,
	// Toward decode
	output logic [31:0] o_pc,
	output logic [31:0] o_instr,
	output logic o_prediction,
	// Predictor training
	input wire i_resolve_vld,
	input wire [31:0] i_resolve_pc,
	input wire i_resolve_taken,
	// Configuration access
	input wire i_cfg_we,
	input wire cfg_addr_e i_cfg_addr,
	input wire [31:0] i_cfg_wdata,
	output logic [31:0] o_cfg_rdata
);

	logic [31:0] trap_vec;
	logic predict_en;
	logic predict_taken;
	logic [31:0] predicted_pc;

	fetch_config u_fetch_config (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_cfg_we     (i_cfg_we),
		.i_cfg_addr   (i_cfg_addr),
		.i_cfg_wdata  (i_cfg_wdata),
		.o_cfg_rdata  (o_cfg_rdata),
		.o_trap_vec   (trap_vec),
		.o_predict_en (predict_en)
	);

	fetch_stage u_fetch_stage (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_rom_instr     (i_rom_instr),
		.i_instr_vld     (i_instr_vld),
		.o_iaddr         (o_iaddr),
		.o_fetch_rdy     (o_fetch_rdy),
		.i_trap          (i_trap),
		.i_trap_vec      (trap_vec),
		.i_boj           (i_boj),
		.i_boj_pc        (i_boj_pc),
		.i_stall         (i_stall),
		.i_flush         (i_flush),
		.i_flush_pc      (i_flush_pc),
		.i_predict_taken (predict_taken),
		.i_predicted_pc  (predicted_pc),
		.o_pc            (o_pc),
		.o_instr         (o_instr),
		.o_prediction    (o_prediction)
	);

	// Looks up the word currently on the ROM bus
	branch_predictor #(
		.BPU_ENTRIES (BPU_ENTRIES)
	) u_branch_predictor (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_fetch_pc      (o_iaddr),
		.i_fetch_instr   (i_rom_instr),
		.i_predict_en    (predict_en),
		.i_resolve_vld   (i_resolve_vld),
		.i_resolve_pc    (i_resolve_pc),
		.i_resolve_taken (i_resolve_taken),
		.o_predict_taken (predict_taken),
		.o_predicted_pc  (predicted_pc)
	);

endmodule

`default_nettype wire

/* verification/fetch_asserts.sv */
// Concurrent checks on the fetch stage that are bound into every fetch_stage instance
// Flush target, PC hold under stall and the ready level during flush

`timescale 1ns/100ps
`default_nettype none

module fetch_asserts (
	input wire clk,
	input wire rst_n,
	input wire i_flush,
	input wire [31:0] i_flush_pc,
	input wire i_stall,
	input wire i_trap,
	input wire i_boj,
	input wire [31:0] i_iaddr,
	input wire i_fetch_rdy
);

	// Failed checks so far
	int fail_cnt = 0;

	// PC lands on the flush target one clock later
	a_flush_target: assert property (@(posedge clk) disable iff (!rst_n)
		i_flush |=> (i_iaddr == $past(i_flush_pc)))
		else begin
			fail_cnt++;
			$error("PC did not take the flush target");
		end

	// Stall with no redirect keeps the address
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(i_stall && !i_flush && !i_trap && !i_boj) |=> $stable(i_iaddr))
		else begin
			fail_cnt++;
			$error("PC moved during a stall");
		end

	a_rdy_flush: assert property (@(posedge clk) disable iff (!rst_n)
		i_flush |-> !i_fetch_rdy)
		else begin
			fail_cnt++;
			$error("Fetch ready was high during a flush");
		end

endmodule

bind fetch_stage fetch_asserts u_fetch_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_flush     (i_flush),
	.i_flush_pc  (i_flush_pc),
	.i_stall     (i_stall),
	.i_trap      (i_trap),
	.i_boj       (i_boj),
	.i_iaddr     (o_iaddr),
	.i_fetch_rdy (o_fetch_rdy)
);

`default_nettype wire

/* verification/fetch_tb.sv */
// Testbench for the fetch unit with a same-cycle ROM model
// Vectors from the pattern file drive redirects, training and config writes
// A cycle model of PC, counter table and config registers is checked every clock
// Run from the project root so the pattern file is found

`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	localparam int ROM_WORDS = 128;
	localparam int VEC_BASE  = 256;
	localparam int IDX_W     = $clog2(BPU_ENTRIES_DEF);

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] i_rom_instr;
	logic i_instr_vld, i_trap, i_boj, i_stall, i_flush;
	logic [31:0] i_boj_pc, i_flush_pc, i_resolve_pc, i_cfg_wdata;
	logic i_resolve_vld, i_resolve_taken, i_cfg_we;
	cfg_addr_e i_cfg_addr;
	logic [31:0] o_iaddr, o_pc, o_instr, o_cfg_rdata;
	logic o_fetch_rdy, o_prediction;

	// ROM words at the bottom and vectors from VEC_BASE
	// All ones marks an entry the file did not write
	logic [111:0] pat_mem [384];
	logic [31:0] rom [ROM_WORDS];
	logic rom_loaded = 1'b0;
	int num_vec;
	int cycles = 0;
	int cycle_limit = 1000;

	// Reference model state
	logic [31:0] m_pc, m_ir_instr, m_ir_pc, m_tvec;
	logic m_ir_pred, m_pen;
	logic [1:0] m_cnt [BPU_ENTRIES_DEF];

	always #4 clk = ~clk;

	fetch_top #(.BPU_ENTRIES(BPU_ENTRIES_DEF)) DUT (.*);

	// Unwritten ROM words hold an addi that folds in every address bit
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[24:0] ^ addr[31:7], OP_IMM};
	endfunction

	function automatic logic [31:0] rom_word(input logic [31:0] addr);
		if (addr < ROM_WORDS * 4) begin
			return rom[addr[8:2]];
		end
		return fill_word(addr);
	endfunction

	// Sign-extended RV32I B-type offset
	function automatic logic [31:0] branch_offset(input logic [31:0] w);
		return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
	endfunction

	// Instruction memory answers in the same cycle
	always @(o_iaddr or rom_loaded) begin
		i_rom_instr = rom_word(o_iaddr);
	end

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			$display("tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_outputs();
		logic [31:0] rdata_exp;
		rdata_exp = (i_cfg_addr == CFG_TVEC) ? m_tvec : {31'd0, m_pen};
		compare("o_iaddr", m_pc, o_iaddr);
		compare("o_pc", m_ir_pc, o_pc);
		compare("o_instr", m_ir_instr, o_instr);
		compare("o_prediction", m_ir_pred, o_prediction);
		compare("o_fetch_rdy", rst_n && !i_stall && !i_flush, o_fetch_rdy);
		compare("o_cfg_rdata", rdata_exp, o_cfg_rdata);
		// Bound checker on the fetch stage
		if (DUT.u_fetch_stage.u_fetch_asserts.fail_cnt != 0) begin
			$display("A concurrent assertion on the fetch stage failed before %0t", $time);
			$display("tests failed");
			$fatal(1, "Assertion failure");
		end
	endtask

	// Field layout matches the comment at the top of the pattern file
	task automatic apply_vector(input logic [111:0] v);
		i_flush         <= v[111];
		i_trap          <= v[110];
		i_boj           <= v[109];
		i_stall         <= v[108] || (v[101] && ($urandom % 4 == 0));
		i_instr_vld     <= v[107];
		i_resolve_vld   <= v[106];
		i_resolve_taken <= v[105];
		i_cfg_we        <= v[104];
		i_cfg_addr      <= cfg_addr_e'(v[100]);
		i_flush_pc      <= v[95:64];
		i_boj_pc        <= v[63:32];
		i_resolve_pc    <= v[31:0];
		i_cfg_wdata     <= v[31:0];
	endtask

	// One clock of the model on the inputs held during the cycle
	task automatic model_step();
		logic [31:0] word;
		logic [IDX_W-1:0] idx;
		logic pred;
		logic adv;
		word = rom_word(m_pc);
		idx  = m_pc[IDX_W+1:2];
		pred = (word[6:0] == BRANCH) && m_pen && (m_cnt[idx] >= 2'd2);
		adv  = i_instr_vld && !i_stall;
		// Decode register takes the old PC
		if (i_flush) begin
			m_ir_instr = NOP_INSTR;
			m_ir_pc    = 32'd0;
			m_ir_pred  = 1'b0;
		end else if (adv) begin
			m_ir_instr = word;
			m_ir_pc    = m_pc;
			m_ir_pred  = pred;
		end
		if (i_flush) m_pc = i_flush_pc;
		else if (i_trap) m_pc = m_tvec;
		else if (i_boj) m_pc = i_boj_pc;
		else if (adv) m_pc = pred ? m_pc + branch_offset(word) : m_pc + 32'd4;
		// Training after lookup saturates at 0 and 3
		if (i_resolve_vld) begin
			idx = i_resolve_pc[IDX_W+1:2];
			if (i_resolve_taken && m_cnt[idx] != 2'd3) m_cnt[idx] = m_cnt[idx] + 2'd1;
			else if (!i_resolve_taken && m_cnt[idx] != 2'd0) m_cnt[idx] = m_cnt[idx] - 2'd1;
		end
		if (i_cfg_we && i_cfg_addr == CFG_TVEC) m_tvec = {i_cfg_wdata[31:2], 2'b00};
		else if (i_cfg_we) m_pen = i_cfg_wdata[0];
	endtask

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: %0d cycles passed before the patterns finished", cycles);
			$display("tests failed");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		int unsigned seed_ret;
		seed_ret = $urandom(31388);
		rst_n = 1'b0;
		apply_vector('0);
		for (int i = 0; i < $size(pat_mem); i++) begin
			pat_mem[i] = '1;
		end
		$readmemh("verification/fetch_patterns.txt", pat_mem);
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = (pat_mem[i] == '1) ? fill_word(i * 4) : pat_mem[i][31:0];
		end
		rom_loaded = 1'b1;
		num_vec = 0;
		while (VEC_BASE + num_vec < $size(pat_mem) && pat_mem[VEC_BASE + num_vec] != '1) begin
			num_vec++;
		end
		if (num_vec == 0) begin
			$display("No stimulus vectors were found in the pattern file");
			$display("tests failed");
			$fatal(1, "Empty pattern file");
		end
		cycle_limit = 2 * num_vec + 20;
		m_pc       = PC_RESET;
		m_ir_instr = NOP_INSTR;
		m_ir_pc    = 32'd0;
		m_ir_pred  = 1'b0;
		m_tvec     = TVEC_RESET;
		m_pen      = 1'b1;
		for (int i = 0; i < BPU_ENTRIES_DEF; i++) begin
			m_cnt[i] = 2'd1;
		end
		// Ready stays low in reset
		@(negedge clk);
		compare("o_fetch_rdy", 32'd0, o_fetch_rdy);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_outputs();
		// Last pass drives idle inputs and checks the final vector
		for (int n = 0; n <= num_vec; n++) begin
			@(posedge clk);
			model_step();
			apply_vector((n < num_vec) ? pat_mem[VEC_BASE + n] : '0);
			@(negedge clk);
			check_outputs();
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/fetch_patterns.txt */
// ROM image from @000 (word index), then one stimulus vector per clock from @100
// Vector RMC0_flushpc_bojpc_aux  R=flush,trap,boj,stall  M=vld,resolve,taken,cfg_we
// C=rand_stall,cfg_addr  aux=resolve_pc and cfg_wdata
@000
00100093 00200113 00308193 00410213 00518293 00620313 00728393 00830413
04000063 // beq x0,x0,+64 at 0x20
@01c
FE0008E3 // beq x0,x0,-16 at 0x70
@100
0800_00000000_00000000_00000000 // sequential fetch
1800_00000000_00000000_00000000 // stall
0820_00000000_00000000_00000000 // random stall
E800_00000040_00000080_00000000 // flush, trap and boj
6800_00000000_00000080_00000000 // trap and boj
2800_00000000_0000000C_00000000 // boj
A800_00000010_00000090_00000000 // flush and boj
9800_00000018_00000000_00000000 // flush during stall
0900_00000000_00000000_00000183 // write trap vector
4800_00000000_00000000_00000000 // trap to written vector
0E00_00000000_00000000_00000020 // train 0x20 taken
0E00_00000000_00000000_00000020
2800_00000000_00000020_00000000
0800_00000000_00000000_00000000 // predicted taken to 0x60
0C00_00000000_00000000_00000020 // train 0x20 not taken
0C00_00000000_00000000_00000020
2800_00000000_00000020_00000000
0800_00000000_00000000_00000000 // falls through to 0x24
0E00_00000000_00000000_00000070 // train backward branch
0E00_00000000_00000000_00000070
2800_00000000_00000070_00000000
0800_00000000_00000000_00000000 // predicted taken to 0x60
0E00_00000000_00000000_00000020
0E00_00000000_00000000_00000020
0910_00000000_00000000_00000000 // clear prediction enable
2810_00000000_00000020_00000000
0810_00000000_00000000_00000000 // falls through with enable clear
0000_00000000_00000000_00000000 // no valid word

/* fetch_top.f */
design/fetch_pkg.sv
design/fetch_config.sv
design/branch_predictor.sv
design/fetch_stage.sv
design/fetch_top.sv
verification/fetch_asserts.sv
verification/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - design/fetch_pkg.sv
  - design/fetch_config.sv
  - design/branch_predictor.sv
  - design/fetch_stage.sv
  - design/fetch_top.sv
  - target: simulation
    files:
      - verification/fetch_asserts.sv
      - verification/fetch_tb.sv
